/* src.f */
board_pkg.sv
bus_pkg.sv
settings_regs.sv
ref_monitor.sv
frontend_ctrl.sv
radio_board.sv
radio_board_checker.sv
tb_radio_board.sv

/* Makefile */
# Verilator build and run for the radio board testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_radio_board
FILELIST  = src.f
SIM_ARGS  = +verilator+error+limit+100
PASS_MSG  = Simulation passed

.PHONY: sim clean

# Build, run, and pass only if the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* tb_radio_board.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////
// Testbench for the radio board control plane
// Table of bus accesses followed by reference lock scenarios
//////////////////////////////////////////////////
module tb_radio_board;
   import bus_pkg::*;
   import board_pkg::*;

   typedef struct packed {
      sb_op_e      op;
      logic [7:0]  addr;
      logic [31:0] wdata;
      logic        run_rx;
      logic        run_tx;
      logic [31:0] exp_rdata;
      logic        exp_err;
      logic        chk_pins;    // Compare fe_pins after the access
   } row_t;

   logic        bus_clk = 1'b0;
   logic        reset_global;
   logic        req;
   sb_req_t     sb_req;
   logic        ack;
   sb_resp_t    sb_resp;
   logic        run_rx;
   logic        run_tx;
   logic        pps_in = 1'b0;
   logic        clkin_10mhz = 1'b0;
   fe_pins_t    fe_pins;
   logic        codec_arst;
   logic        clkin_10mhz_req;

   row_t        rows[$];
   logic [31:0] atr_model[4];          // Expected ATR regs indexed by {run_tx, run_rx}
   logic [31:0] rdata;
   logic        err;
   int          mismatches = 0;
   int          failures   = 0;
   int          ref_period = 0;        // Pulse spacing in cycles or 0 for off
   logic        ref_fast   = 1'b0;     // Pulses on clkin_10mhz instead of pps_in
   int          ref_cnt    = 0;

   radio_board u_dut (.*);

   always #4 bus_clk = ~bus_clk;

   ////////////////////////////////////////////////// Reference pulse source
   always @(posedge bus_clk) begin
      #1;
      if (ref_period != 0 && ref_cnt >= ref_period - 1) begin
         ref_cnt     = 0;
         pps_in      = ~ref_fast;   // One cycle wide
         clkin_10mhz = ref_fast;
      end else begin
         ref_cnt     = (ref_period != 0) ? ref_cnt + 1 : 0;
         pps_in      = 1'b0;
         clkin_10mhz = 1'b0;
      end
   end

   // Board pins from ATR byte with LEDs active low
   function automatic logic [9:0] map_pins(input logic [7:0] atr, input logic locked,
                                          input logic present);
      return {~present, ~locked, atr[7:3], ~atr[2:0]};
   endfunction

   task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         mismatches++;
         $display("mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      end
   endtask

   // One four-phase transfer entered 1 ns after an edge
   task automatic bus_xfer(input sb_op_e op, input logic [7:0] addr, input logic [31:0] data,
                           output logic [31:0] rd, output logic rerr);
      int t;
      sb_req.op   = op;
      sb_req.addr = addr;
      sb_req.data = data;
      req         = 1'b1;
      t           = 0;
      while (ack !== 1'b1 && t < 16) begin
         @(posedge bus_clk);
         #1;
         t++;
      end
      if (ack !== 1'b1) begin
         failures++;
         $display("ack never rose for access to address 0x%0h", addr);
      end
      rd   = sb_resp.rdata;
      rerr = sb_resp.err;
      req  = 1'b0;
      t    = 0;
      while (ack !== 1'b0 && t < 16) begin
         @(posedge bus_clk);
         #1;
         t++;
      end
      if (ack !== 1'b0) begin
         failures++;
         $display("ack stayed high after req dropped, address 0x%0h", addr);
      end
   endtask

   task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp);
      logic [31:0] rd;
      logic        rerr;
      bus_xfer(SB_READ, addr, 32'h0, rd, rerr);
      expect_eq("sb_resp.rdata", rd, exp);
      expect_eq("sb_resp.err", rerr, 32'h0);
   endtask

   task automatic wait_pins(input logic [9:0] mask, input logic [9:0] val, input int max_cyc,
                            input string what);
      int t;
      t = 0;
      while ((fe_pins & mask) !== val && t < max_cyc) begin
         @(posedge bus_clk);
         #1;
         t++;
      end
      if ((fe_pins & mask) !== val) begin
         failures++;
         $display("no %s within %0d cycles", what, max_cyc);
      end
   endtask

   task automatic add_row(input sb_op_e op, input logic [7:0] addr, input logic [31:0] wdata,
                          input logic rx, input logic tx, input logic [31:0] exp_rd,
                          input logic exp_err, input logic chk);
      rows.push_back('{op, addr, wdata, rx, tx, exp_rd, exp_err, chk});
   endtask

   initial begin
      logic [31:0] w[4];
      int          idx;
      logic        seen_present;
      logic        seen_lock;
      void'($urandom(43));
      reset_global = 1'b1;
      req          = 1'b0;
      sb_req       = '0;
      run_rx       = 1'b0;
      run_tx       = 1'b0;
      foreach (atr_model[k]) atr_model[k] = '0;
      foreach (w[k]) w[k] = $urandom();   // ATR contents for this run
      repeat (2) @(posedge bus_clk);
      #1;
      reset_global = 1'b0;

      ////////////////////////////////////////////////// Reset state
      expect_eq("ack", ack, 32'h0);
      expect_eq("codec_arst", codec_arst, 32'h0);
      expect_eq("clkin_10mhz_req", clkin_10mhz_req, 32'h0);
      expect_eq("fe_pins", fe_pins, map_pins(8'h00, 1'b0, 1'b0));

      // Table columns op, addr, wdata, run_rx, run_tx, rdata, err, pins
      add_row(SB_READ,  REG_STATUS, 32'h0, 0, 0, 32'h0, 0, 1);
      add_row(SB_WRITE, REG_MISC,   32'h5, 0, 0, 32'h5, 0, 0);   // ref_sel and codec_arst
      add_row(SB_READ,  REG_MISC,   32'h0, 0, 0, 32'h5, 0, 0);
      for (int k = 0; k < 4; k++) add_row(SB_WRITE, 8'h04 + 8'(4 * k), w[k], 0, 0, w[k], 0, 0);
      for (int k = 0; k < 4; k++) add_row(SB_READ, 8'h04 + 8'(4 * k), 32'h0, 0, 0, w[k], 0, 0);
      add_row(SB_READ,  8'h18,      32'h0,         0, 0, 32'h0, 1, 0);   // Unmapped
      add_row(SB_WRITE, 8'h18,      32'hFFFF_FFFF, 0, 0, 32'h0, 1, 0);
      add_row(SB_WRITE, REG_STATUS, 32'hFFFF_FFFF, 0, 0, 32'h0, 1, 0);   // Read only
      add_row(SB_READ,  REG_MISC,   32'h0,         0, 0, 32'h5, 0, 0);
      for (int k = 0; k < 4; k++) add_row(SB_READ, 8'h04 + 8'(4 * k), 32'h0, 0, 0, w[k], 0, 0);
      for (int k = 0; k < 4; k++) add_row(SB_READ, REG_STATUS, 32'h0, k[0], k[1], 32'h0, 0, 1);

      foreach (rows[i]) begin
         run_rx = rows[i].run_rx;
         run_tx = rows[i].run_tx;
         bus_xfer(rows[i].op, rows[i].addr, rows[i].wdata, rdata, err);
         expect_eq("sb_resp.rdata", rdata, rows[i].exp_rdata);
         expect_eq("sb_resp.err", err, rows[i].exp_err);
         idx = (rows[i].addr >> 2) - 1;   // ATR slot or -1 for misc
         if (rows[i].op == SB_WRITE && !rows[i].exp_err && idx >= 0 && idx < 4) begin
            atr_model[idx] = rows[i].wdata;
         end
         if (rows[i].chk_pins) begin
            expect_eq("fe_pins", fe_pins, map_pins(atr_model[{run_tx, run_rx}][7:0], 0, 0));
         end
      end
      expect_eq("codec_arst", codec_arst, 32'h1);
      expect_eq("clkin_10mhz_req", clkin_10mhz_req, 32'h1);

      ////////////////////////////////////////////////// Reference lock
      bus_xfer(SB_WRITE, REG_MISC, 32'h2, rdata, err);   // PPS select
      ref_fast   = 1'b0;
      ref_period = REF_PPS_PERIOD;
      wait_pins(10'h100, 10'h000, 6 * REF_PPS_PERIOD, "PPS lock");
      read_expect(REG_STATUS, 32'h3);
      ref_period = 0;   // Reference gone
      wait_pins(10'h300, 10'h300, 4 * REF_PPS_PERIOD, "loss of reference");
      read_expect(REG_STATUS, 32'h0);

      // 50 cycle PPS is out of tolerance
      ref_period   = REF_PPS_PERIOD + 10;
      seen_present = 1'b0;
      seen_lock    = 1'b0;
      for (int c = 0; c < 8 * (REF_PPS_PERIOD + 10); c++) begin
         @(posedge bus_clk);
         #1;
         if (!fe_pins.led_s1) seen_present = 1'b1;
         if (!fe_pins.led_s0) seen_lock = 1'b1;
      end
      if (!seen_present) begin
         failures++;
         $display("reference never reported present with a 50 cycle PPS");
      end
      if (seen_lock) begin
         failures++;
         $display("lock reported for a 50 cycle PPS");
      end

      bus_xfer(SB_WRITE, REG_MISC, 32'h1, rdata, err);   // 10 MHz select
      ref_fast   = 1'b1;
      ref_period = REF_10M_PERIOD;
      wait_pins(10'h100, 10'h000, 10 * REF_10M_PERIOD, "10 MHz lock");
      read_expect(REG_STATUS, 32'h3);
      expect_eq("clkin_10mhz_req", clkin_10mhz_req, 32'h1);

      $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
               mismatches, failures, u_dut.u_chk.fail_cnt);
      if (mismatches + failures + u_dut.u_chk.fail_cnt == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* radio_board_checker.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////
// Concurrent assertions on the settings bus handshake and reset pins
// Attached to every radio_board instance by the bind at the bottom
//////////////////////////////////////////////////
module radio_board_checker (
   input logic                bus_clk,
   input logic                reset_global,
   input logic                req,
   input logic                ack,
   input bus_pkg::sb_resp_t   sb_resp,
   input board_pkg::fe_pins_t fe_pins
);
   int unsigned fail_cnt = 0;   // Failed assertions so far

   // ack only ever answers a request
   a_ack_needs_req: assert property (@(posedge bus_clk) disable iff (reset_global)
      $rose(ack) |-> $past(req))
      else begin
         fail_cnt++;
         $error("ack rose with req low");
      end

   // Host may only let go of req once ack is up
   a_req_held: assert property (@(posedge bus_clk) disable iff (reset_global)
      $fell(req) |-> ack)
      else begin
         fail_cnt++;
         $error("req dropped before ack");
      end

   a_resp_stable: assert property (@(posedge bus_clk) disable iff (reset_global)
      ack |=> !ack || $stable(sb_resp))   // Response frozen under ack
      else begin
         fail_cnt++;
         $error("sb_resp changed while ack high");
      end

   // All five LEDs dark in reset
   a_leds_off: assert property (@(posedge bus_clk)
      reset_global |-> &{fe_pins.led_s1, fe_pins.led_s0, fe_pins.led_rx2_g,
                         fe_pins.led_trx_g, fe_pins.led_trx_r})
      else begin
         fail_cnt++;
         $error("LED lit during reset");
      end

endmodule

bind radio_board radio_board_checker u_chk (
   .bus_clk(bus_clk), .reset_global(reset_global), .req(req), .ack(ack),
   .sb_resp(sb_resp), .fe_pins(fe_pins)
);

/* radio_board.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////
// Bus-clock control plane top for the radio board
// Settings bus in, front-end pins and reference controls out
//////////////////////////////////////////////////
module radio_board (
   input  logic                bus_clk,
   input  logic                reset_global,
   // Settings bus
   input  logic                req,
   input  bus_pkg::sb_req_t    sb_req,
   output logic                ack,
   output bus_pkg::sb_resp_t   sb_resp,
   // Radio run state
   input  logic                run_rx,
   input  logic                run_tx,
   // External reference
   input  logic                pps_in,
   input  logic                clkin_10mhz,
   // Board outputs
   output board_pkg::fe_pins_t fe_pins,
   output logic                codec_arst,
   output logic                clkin_10mhz_req
);
   import board_pkg::*;

   misc_t       misc;
   fe_atr_t     atr_idle;
   fe_atr_t     atr_rx;
   fe_atr_t     atr_tx;
   fe_atr_t     atr_fdx;
   ref_status_t ref_status;   // To status reg and LEDs

   settings_regs u_regs (
      .bus_clk(bus_clk), .reset_global(reset_global),
      .req(req), .sb_req(sb_req), .ack(ack), .sb_resp(sb_resp),
      .ref_status(ref_status), .misc(misc),
      .atr_idle(atr_idle), .atr_rx(atr_rx), .atr_tx(atr_tx), .atr_fdx(atr_fdx)
   );

   ref_monitor u_ref (
      .bus_clk(bus_clk), .reset_global(reset_global),
      .pps_in(pps_in), .clkin_10mhz(clkin_10mhz),
      .misc(misc), .ref_status(ref_status)
   );

   frontend_ctrl u_fe (
      .bus_clk(bus_clk), .reset_global(reset_global),
      .run_rx(run_rx), .run_tx(run_tx),
      .atr_idle(atr_idle), .atr_rx(atr_rx), .atr_tx(atr_tx), .atr_fdx(atr_fdx),
      .ref_status(ref_status), .fe_pins(fe_pins)
   );

   assign codec_arst      = misc.codec_arst;
   assign clkin_10mhz_req = misc.ref_sel;   // Ask board for 10 MHz

endmodule

/* frontend_ctrl.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////
// Front-end pin driver from ATR words and run state
// Registered outputs, LEDs inverted to active low
//////////////////////////////////////////////////
module frontend_ctrl (
   input  logic                   bus_clk,
   input  logic                   reset_global,
   input  logic                   run_rx,
   input  logic                   run_tx,
   input  board_pkg::fe_atr_t     atr_idle,
   input  board_pkg::fe_atr_t     atr_rx,
   input  board_pkg::fe_atr_t     atr_tx,
   input  board_pkg::fe_atr_t     atr_fdx,
   input  board_pkg::ref_status_t ref_status,
   output board_pkg::fe_pins_t    fe_pins
);
   import board_pkg::*;

   atr_state_e atr_state;
   fe_atr_t    atr_word;    // Word for current state
   fe_pins_t   pins_d;
   fe_pins_t   pins_q;

   // Run state decode
   always_comb begin
      case ({run_tx, run_rx})
         2'b01:   atr_state = ATR_RX;
         2'b10:   atr_state = ATR_TX;
         2'b11:   atr_state = ATR_FDX;   // Full duplex
         default: atr_state = ATR_IDLE;
      endcase
   end

   always_comb begin
      case (atr_state)
         ATR_RX:  atr_word = atr_rx;
         ATR_TX:  atr_word = atr_tx;
         ATR_FDX: atr_word = atr_fdx;
         default: atr_word = atr_idle;
      endcase
   end

   //////////////////////////////////////////////////
   // Pin mapping
   //////////////////////////////////////////////////
   always_comb begin
      pins_d.sel_trx_rx = atr_word.sel_trx_rx;   // Switches pass straight
      pins_d.sel_rx_trx = atr_word.sel_rx_trx;
      pins_d.sel_trx_tx = atr_word.sel_trx_tx;
      pins_d.sel_rx_rx2 = atr_word.sel_rx_rx2;
      pins_d.txdrv_pwen = atr_word.txdrv_pwen;
      pins_d.led_trx_r  = ~atr_word.led_trx_r;
      pins_d.led_trx_g  = ~atr_word.led_trx_g;
      pins_d.led_rx2_g  = ~atr_word.led_rx2_g;
      pins_d.led_s0     = ~ref_status.locked;    // Lit when locked
      pins_d.led_s1     = ~ref_status.present;   // Lit when ref seen
   end

   always_ff @(posedge bus_clk or posedge reset_global) begin
      if (reset_global) begin
         pins_q <= FE_PINS_OFF;
      end else begin
         pins_q <= pins_d;   // One cycle behind inputs
      end
   end

   assign fe_pins = pins_q;

endmodule

/* ref_monitor.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////
// Reference monitor for PPS or 10 MHz input
// Measures edge period in bus_clk cycles, reports presence and lock
//////////////////////////////////////////////////
module ref_monitor (
   input  logic                   bus_clk,
   input  logic                   reset_global,
   input  logic                   pps_in,        // Async
   input  logic                   clkin_10mhz,   // Async, scaled rate
   input  board_pkg::misc_t       misc,
   output board_pkg::ref_status_t ref_status
);
   import board_pkg::*;

   typedef enum logic [1:0] {SRC_NONE, SRC_10M, SRC_PPS} ref_src_e;

   ref_src_e                src;
   ref_src_e                src_q;
   logic                    ref_raw;
   logic [1:0]              sync_q;       // 2-flop synchronizer
   logic                    prev_q;
   logic                    ref_edge;
   logic [REF_CNT_W-1:0]    nominal;
   logic [REF_CNT_W-1:0]    per_cnt_q;    // Cycles since last edge
   logic                    in_tol;
   logic                    timeout;
   logic                    armed_q;      // Previous edge seen, period valid
   logic [REF_GOOD_W-1:0]   good_cnt_q;
   logic                    locked_q;
   logic                    present_q;

   // PPS wins over 10 MHz
   always_comb begin
      if (misc.ref_is_pps) begin
         src = SRC_PPS;
      end else if (misc.ref_sel) begin
         src = SRC_10M;
      end else begin
         src = SRC_NONE;
      end
      case (src)
         SRC_PPS: ref_raw = pps_in;
         SRC_10M: ref_raw = clkin_10mhz;
         default: ref_raw = 1'b0;   // Nothing selected
      endcase
   end

   always_ff @(posedge bus_clk or posedge reset_global) begin
      if (reset_global) begin
         sync_q <= '0;
         prev_q <= 1'b0;
      end else begin
         sync_q <= {sync_q[0], ref_raw};
         prev_q <= sync_q[1];
      end
   end

   assign ref_edge = sync_q[1] & ~prev_q;   // Rising edge only
   assign nominal  = (src == SRC_PPS) ? REF_CNT_W'(REF_PPS_PERIOD) : REF_CNT_W'(REF_10M_PERIOD);
   assign in_tol   = (per_cnt_q >= nominal - REF_CNT_W'(REF_TOL)) &&
                     (per_cnt_q <= nominal + REF_CNT_W'(REF_TOL));
   assign timeout  = per_cnt_q >= nominal + REF_CNT_W'(REF_TOL + 1);

   //////////////////////////////////////////////////
   // Period check and lock
   //////////////////////////////////////////////////
   always_ff @(posedge bus_clk or posedge reset_global) begin
      if (reset_global) begin
         src_q      <= SRC_NONE;
         per_cnt_q  <= '0;
         armed_q    <= 1'b0;
         good_cnt_q <= '0;
         locked_q   <= 1'b0;
         present_q  <= 1'b0;
      end else begin
         src_q <= src;
         if (per_cnt_q != '1) begin
            per_cnt_q <= per_cnt_q + 1'b1;   // Saturates once ref is gone
         end
         if (src != src_q) begin   // New source, start over
            armed_q    <= 1'b0;
            good_cnt_q <= '0;
            locked_q   <= 1'b0;
         end else if (ref_edge) begin
            per_cnt_q <= REF_CNT_W'(1);
            present_q <= 1'b1;
            armed_q   <= 1'b1;
            if (armed_q && in_tol) begin
               if (good_cnt_q < REF_GOOD_W'(REF_LOCK_COUNT)) begin
                  good_cnt_q <= good_cnt_q + 1'b1;
               end
               if (good_cnt_q >= REF_GOOD_W'(REF_LOCK_COUNT - 1)) begin
                  locked_q <= 1'b1;
               end
            end else if (armed_q) begin   // Bad period
               good_cnt_q <= '0;
               locked_q   <= 1'b0;
            end
         end else if (timeout) begin   // Edge overdue
            present_q  <= 1'b0;
            armed_q    <= 1'b0;
            good_cnt_q <= '0;
            locked_q   <= 1'b0;
         end
      end
   end

   assign ref_status = '{present: present_q, locked: locked_q};

endmodule

/* settings_regs.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////
// Settings bus slave with control, ATR and status registers
// Host does four-phase req/ack, one access per handshake
//////////////////////////////////////////////////
module settings_regs (
   input  logic                   bus_clk,
   input  logic                   reset_global,
   input  logic                   req,          // Four-phase request
   input  bus_pkg::sb_req_t       sb_req,
   output logic                   ack,
   output bus_pkg::sb_resp_t      sb_resp,
   input  board_pkg::ref_status_t ref_status,   // For REG_STATUS
   output board_pkg::misc_t       misc,
   output board_pkg::fe_atr_t     atr_idle,
   output board_pkg::fe_atr_t     atr_rx,
   output board_pkg::fe_atr_t     atr_tx,
   output board_pkg::fe_atr_t     atr_fdx
);
   import bus_pkg::*;
   import board_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,       // Waiting for req
      ST_ACK,        // Access done, ack just raised
      ST_WAIT_REL    // Holding ack until host lets go
   } hs_state_e;

   hs_state_e                    state_q;
   misc_t                        misc_q;
   logic [3:0][SB_DATA_W-1:0]    atr_q;       // Indexed by atr_state_e
   logic                         accept;
   logic                         is_write;
   logic                         wr_misc;
   logic [3:0]                   wr_atr;
   logic [SB_DATA_W-1:0]         acc_rdata;
   logic                         acc_err;

   //////////////////////////////////////////////////
   // Handshake FSM
   //////////////////////////////////////////////////
   assign accept = (state_q == ST_IDLE) && req;   // Access edge
   assign ack    = (state_q != ST_IDLE);

   always_ff @(posedge bus_clk or posedge reset_global) begin
      if (reset_global) begin
         state_q <= ST_IDLE;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (req) begin
                  state_q <= ST_ACK;
               end
            end
            ST_ACK: begin
               state_q <= req ? ST_WAIT_REL : ST_IDLE;   // Short pulse host
            end
            ST_WAIT_REL: begin
               if (!req) begin
                  state_q <= ST_IDLE;   // ack drops here
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Address decode
   //////////////////////////////////////////////////
   always_comb begin
      is_write  = (sb_req.op == SB_WRITE);
      wr_misc   = 1'b0;
      wr_atr    = '0;
      acc_rdata = '0;
      acc_err   = 1'b0;
      case (sb_req.addr)
         REG_MISC: begin
            wr_misc   = accept & is_write;
            acc_rdata = is_write ? sb_req.data : misc_q;
         end
         REG_ATR_IDLE: begin
            wr_atr[ATR_IDLE] = accept & is_write;
            acc_rdata        = is_write ? sb_req.data : atr_q[ATR_IDLE];
         end
         REG_ATR_RX: begin
            wr_atr[ATR_RX] = accept & is_write;
            acc_rdata      = is_write ? sb_req.data : atr_q[ATR_RX];
         end
         REG_ATR_TX: begin
            wr_atr[ATR_TX] = accept & is_write;
            acc_rdata      = is_write ? sb_req.data : atr_q[ATR_TX];
         end
         REG_ATR_FDX: begin
            wr_atr[ATR_FDX] = accept & is_write;
            acc_rdata       = is_write ? sb_req.data : atr_q[ATR_FDX];
         end
         REG_STATUS: begin
            acc_err   = is_write;   // Read only
            acc_rdata = is_write ? '0 : {{(SB_DATA_W-2){1'b0}}, ref_status};
         end
         default: acc_err = 1'b1;   // Unmapped, rdata stays zero
      endcase
   end

   // Register file and response, both land on the access edge
   always_ff @(posedge bus_clk or posedge reset_global) begin
      if (reset_global) begin
         misc_q  <= '0;
         atr_q   <= '0;
         sb_resp <= '0;
      end else begin
         if (wr_misc) begin
            misc_q <= sb_req.data;
         end
         for (int i = 0; i < 4; i++) begin
            if (wr_atr[i]) begin
               atr_q[i] <= sb_req.data;
            end
         end
         if (accept) begin
            sb_resp.rdata <= acc_rdata;   // Held through ack high
            sb_resp.err   <= acc_err;
         end
      end
   end

   assign misc     = misc_q;
   assign atr_idle = atr_q[ATR_IDLE][7:0];   // Upper bits only read back
   assign atr_rx   = atr_q[ATR_RX][7:0];
   assign atr_tx   = atr_q[ATR_TX][7:0];
   assign atr_fdx  = atr_q[ATR_FDX][7:0];

endmodule

/* bus_pkg.sv */
//////////////////////////////////////////////////
// Settings bus types shared by host port and register bank
//////////////////////////////////////////////////
package bus_pkg;

   localparam int SB_ADDR_W = 8;
   localparam int SB_DATA_W = 32;

   typedef enum logic {
      SB_READ  = 1'b0,
      SB_WRITE = 1'b1
   } sb_op_e;

   // Host side, held stable while req is high
   typedef struct packed {
      sb_op_e                 op;
      logic [SB_ADDR_W-1:0]   addr;
      logic [SB_DATA_W-1:0]   data;   // Write data, ignored on read
   } sb_req_t;

   // Slave side, valid while ack is high
   typedef struct packed {
      logic [SB_DATA_W-1:0]   rdata;
      logic                   err;    // Bad address or read-only write
   } sb_resp_t;

endpackage

/* board_pkg.sv */
//////////////////////////////////////////////////
// Board-level types and constants for the radio control plane
// Register map, ATR word layout, pin bundle and reference timing
//////////////////////////////////////////////////
package board_pkg;

   // Settings register map, byte addresses
   typedef enum logic [7:0] {
      REG_MISC     = 8'h00,
      REG_ATR_IDLE = 8'h04,
      REG_ATR_RX   = 8'h08,
      REG_ATR_TX   = 8'h0C,
      REG_ATR_FDX  = 8'h10,
      REG_STATUS   = 8'h14    // Read only
   } reg_addr_e;

   typedef struct packed {
      logic [28:0] spare;
      logic        codec_arst;   // Codec async reset
      logic        ref_is_pps;   // PPS select, wins over ref_sel
      logic        ref_sel;      // 10 MHz select and request
   } misc_t;

   // ATR word, low byte of each ATR register, all active high
   typedef struct packed {
      logic txdrv_pwen;   // Bit 7
      logic sel_rx_rx2;
      logic sel_trx_tx;
      logic sel_rx_trx;
      logic sel_trx_rx;
      logic led_rx2_g;
      logic led_trx_g;
      logic led_trx_r;    // Bit 0
   } fe_atr_t;

   // Board pins, LED bits active low
   typedef struct packed {
      logic led_s1;       // Reference present
      logic led_s0;       // Reference locked
      logic txdrv_pwen;
      logic sel_rx_rx2;
      logic sel_trx_tx;
      logic sel_rx_trx;
      logic sel_trx_rx;
      logic led_rx2_g;
      logic led_trx_g;
      logic led_trx_r;
   } fe_pins_t;

   // Switches open, PA off, every LED dark
   localparam fe_pins_t FE_PINS_OFF = '{led_s1: 1'b1, led_s0: 1'b1, led_rx2_g: 1'b1,
                                        led_trx_g: 1'b1, led_trx_r: 1'b1, default: 1'b0};

   typedef struct packed {
      logic present;   // Status bit 1
      logic locked;    // Status bit 0
   } ref_status_t;

   typedef enum logic [1:0] {ATR_IDLE, ATR_RX, ATR_TX, ATR_FDX} atr_state_e;

   ////////////////////////////////////////////////// Reference timing
   localparam int REF_PPS_PERIOD = 40;   // Scaled down, bus_clk cycles
   localparam int REF_10M_PERIOD = 10;
   localparam int REF_TOL        = 1;
   localparam int REF_LOCK_COUNT = 3;    // Good periods to lock
   localparam int REF_CNT_W      = 8;
   localparam int REF_GOOD_W     = $clog2(REF_LOCK_COUNT + 1);

endpackage
